/* mmio_consts.svh */
//************************************************
// MMIO peripheral constants
// bus window, register offsets and reset values
//************************************************
`ifndef MMIO_CONSTS_SVH
`define MMIO_CONSTS_SVH

// upper 24 address bits of the 256-byte window
`define MMIO_BASE 24'h030000

`define MMIO_DATA_W 32
`define MMIO_GPIO_W 16

// gpio control
`define MMIO_OFF_GPIO_DAT 8'h00
`define MMIO_OFF_GPIO_OEB 8'h04
`define MMIO_OFF_GPIO_PU 8'h08
`define MMIO_OFF_GPIO_PD 8'h0c

// read-only strap and id words
`define MMIO_OFF_STRAP_CFG 8'h18
`define MMIO_OFF_STRAP_XTAL 8'h1c
`define MMIO_OFF_STRAP_PLL 8'h20
`define MMIO_OFF_MFGR_ID 8'h24
`define MMIO_OFF_PROD_ID 8'h28
`define MMIO_OFF_MASK_REV 8'h2c
`define MMIO_OFF_CLK_SEL 8'h30

// counter timer
`define MMIO_OFF_TIM_CFG 8'h5c
`define MMIO_OFF_TIM_VAL 8'h60
`define MMIO_OFF_TIM_DAT 8'h64

// pads stay tri-stated until software enables them
`define GPIO_OEB_RESET 16'hffff

`endif

/* mmio_pkg.sv */
//************************************************
// MMIO peripheral types
// register select and bus controller states
//************************************************
package mmio_pkg;

  // one member per mapped register offset
  typedef enum logic [3:0] {
    REG_NONE,
    REG_GPIO_DAT,
    REG_GPIO_OEB,
    REG_GPIO_PU,
    REG_GPIO_PD,
    REG_STRAP_CFG,
    REG_STRAP_XTAL,
    REG_STRAP_PLL,
    REG_MFGR_ID,
    REG_PROD_ID,
    REG_MASK_REV,
    REG_CLK_SEL,
    REG_TIM_CFG,
    REG_TIM_VAL,
    REG_TIM_DAT
  } mmio_reg_e;

  // accept in idle, answer in resp
  typedef enum logic {
    BUS_IDLE,
    BUS_RESP
  } bus_state_e;

endpackage

/* mmio_bus_ctrl.sv */
//************************************************
// MMIO bus controller
// decodes the window, sequences ready and
// registers the read word of the selected group
//************************************************
`timescale 1ns/1ns
`include "mmio_consts.svh"

module mmio_bus_ctrl import mmio_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    mem_valid_i,
  input  logic [`MMIO_DATA_W-1:0] mem_addr_i,
  input  logic [3:0]              mem_wstrb_i,
  input  logic [`MMIO_DATA_W-1:0] gpio_rdata_i,
  input  logic [`MMIO_DATA_W-1:0] tim_rdata_i,
  input  logic [`MMIO_DATA_W-1:0] info_rdata_i,
  output mmio_reg_e               sel_o,
  output logic                    wr_stb_o,
  output logic                    mem_ready_o,
  output logic [`MMIO_DATA_W-1:0] mem_rdata_o
);

  bus_state_e              state_q;
  bus_state_e              state_d;
  logic                    mapped;
  mmio_reg_e               dec_sel;
  logic [`MMIO_DATA_W-1:0] rd_word;
  logic [`MMIO_DATA_W-1:0] rdata_q;

  // anything outside the window is left unanswered
  assign mapped = mem_valid_i && (mem_addr_i[`MMIO_DATA_W-1:8] == `MMIO_BASE);

  always_comb begin
    case (mem_addr_i[7:0])
      `MMIO_OFF_GPIO_DAT:   dec_sel = REG_GPIO_DAT;
      `MMIO_OFF_GPIO_OEB:   dec_sel = REG_GPIO_OEB;
      `MMIO_OFF_GPIO_PU:    dec_sel = REG_GPIO_PU;
      `MMIO_OFF_GPIO_PD:    dec_sel = REG_GPIO_PD;
      `MMIO_OFF_STRAP_CFG:  dec_sel = REG_STRAP_CFG;
      `MMIO_OFF_STRAP_XTAL: dec_sel = REG_STRAP_XTAL;
      `MMIO_OFF_STRAP_PLL:  dec_sel = REG_STRAP_PLL;
      `MMIO_OFF_MFGR_ID:    dec_sel = REG_MFGR_ID;
      `MMIO_OFF_PROD_ID:    dec_sel = REG_PROD_ID;
      `MMIO_OFF_MASK_REV:   dec_sel = REG_MASK_REV;
      `MMIO_OFF_CLK_SEL:    dec_sel = REG_CLK_SEL;
      `MMIO_OFF_TIM_CFG:    dec_sel = REG_TIM_CFG;
      `MMIO_OFF_TIM_VAL:    dec_sel = REG_TIM_VAL;
      `MMIO_OFF_TIM_DAT:    dec_sel = REG_TIM_DAT;
      default:              dec_sel = REG_NONE;
    endcase
  end

  assign sel_o = mapped ? dec_sel : REG_NONE;

  // group mux, unlisted offsets read as zero
  always_comb begin
    case (sel_o)
      REG_GPIO_DAT, REG_GPIO_OEB, REG_GPIO_PU, REG_GPIO_PD: begin
        rd_word = gpio_rdata_i;
      end
      REG_TIM_CFG, REG_TIM_VAL, REG_TIM_DAT: begin
        rd_word = tim_rdata_i;
      end
      REG_STRAP_CFG, REG_STRAP_XTAL, REG_STRAP_PLL, REG_MFGR_ID,
      REG_PROD_ID, REG_MASK_REV, REG_CLK_SEL: begin
        rd_word = info_rdata_i;
      end
      default: rd_word = '0;
    endcase
  end

  always_comb begin
    state_d = BUS_IDLE;
    if (state_q == BUS_IDLE && mapped) begin
      state_d = BUS_RESP;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= BUS_IDLE;
      rdata_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == BUS_IDLE && mapped) begin
        rdata_q <= rd_word;
      end
    end
  end

  // write lands on the same edge that sees ready
  assign wr_stb_o    = (state_q == BUS_RESP) && (|mem_wstrb_i);
  assign mem_ready_o = (state_q == BUS_RESP);
  assign mem_rdata_o = rdata_q;

endmodule

/* mmio_gpio_regs.sv */
//************************************************
// GPIO control registers
// data, oeb, pull-up-bar and pull-down-bar
//************************************************
`timescale 1ns/1ns
`include "mmio_consts.svh"

module mmio_gpio_regs import mmio_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  mmio_reg_e               sel_i,
  input  logic                    wr_stb_i,
  input  logic [`MMIO_DATA_W-1:0] wdata_i,
  input  logic [3:0]              wstrb_i,
  input  logic [`MMIO_GPIO_W-1:0] gpio_in_i,
  output logic [`MMIO_DATA_W-1:0] rdata_o,
  output logic [`MMIO_GPIO_W-1:0] gpio_out_o,
  output logic [`MMIO_GPIO_W-1:0] gpio_outenb_o,
  output logic [`MMIO_GPIO_W-1:0] gpio_pullupb_o,
  output logic [`MMIO_GPIO_W-1:0] gpio_pulldownb_o
);

  logic [`MMIO_GPIO_W-1:0] out_q;
  logic [`MMIO_GPIO_W-1:0] oeb_q;
  logic [`MMIO_GPIO_W-1:0] pu_q;
  logic [`MMIO_GPIO_W-1:0] pd_q;

  // low and high byte under their own strobe
  function automatic logic [`MMIO_GPIO_W-1:0] merge_bytes(
    input logic [`MMIO_GPIO_W-1:0] cur,
    input logic [`MMIO_GPIO_W-1:0] wd,
    input logic [1:0]              strb
  );
    logic [`MMIO_GPIO_W-1:0] res;
    res = cur;
    if (strb[0]) res[7:0] = wd[7:0];
    if (strb[1]) res[15:8] = wd[15:8];
    return res;
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q <= '0;
      oeb_q <= `GPIO_OEB_RESET;
      pu_q  <= '0;
      pd_q  <= '0;
    end else if (wr_stb_i) begin
      case (sel_i)
        REG_GPIO_DAT: out_q <= merge_bytes(out_q, wdata_i[15:0], wstrb_i[1:0]);
        REG_GPIO_OEB: oeb_q <= merge_bytes(oeb_q, wdata_i[15:0], wstrb_i[1:0]);
        REG_GPIO_PU:  pu_q  <= merge_bytes(pu_q, wdata_i[15:0], wstrb_i[1:0]);
        REG_GPIO_PD:  pd_q  <= merge_bytes(pd_q, wdata_i[15:0], wstrb_i[1:0]);
        default: ;
      endcase
    end
  end

  always_comb begin
    case (sel_i)
      REG_GPIO_DAT: rdata_o = {out_q, gpio_in_i};
      REG_GPIO_OEB: rdata_o = {16'd0, oeb_q};
      REG_GPIO_PU:  rdata_o = {16'd0, pu_q};
      REG_GPIO_PD:  rdata_o = {16'd0, pd_q};
      default:      rdata_o = '0;
    endcase
  end

  assign gpio_out_o       = out_q;
  // pads must not drive while the chip is held in reset
  assign gpio_outenb_o    = oeb_q | {`MMIO_GPIO_W{~rst_n_i}};
  assign gpio_pullupb_o   = pu_q;
  assign gpio_pulldownb_o = pd_q;

endmodule

/* mmio_timer.sv */
//************************************************
// MMIO counter timer
// down counter with reload, one-shot or
// continuous mode
//************************************************
`timescale 1ns/1ns
`include "mmio_consts.svh"

module mmio_timer import mmio_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  mmio_reg_e               sel_i,
  input  logic                    wr_stb_i,
  input  logic [`MMIO_DATA_W-1:0] wdata_i,
  input  logic [3:0]              wstrb_i,
  output logic [`MMIO_DATA_W-1:0] rdata_o
);

  logic                    en_q;
  logic                    cont_q;
  logic [`MMIO_DATA_W-1:0] val_q;
  logic [`MMIO_DATA_W-1:0] cnt_q;

  function automatic logic [`MMIO_DATA_W-1:0] merge_word(
    input logic [`MMIO_DATA_W-1:0] cur,
    input logic [`MMIO_DATA_W-1:0] wd,
    input logic [3:0]              strb
  );
    logic [`MMIO_DATA_W-1:0] res;
    res = cur;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = wd[8*b +: 8];
    end
    return res;
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en_q   <= 1'b0;
      cont_q <= 1'b0;
      val_q  <= '0;
      cnt_q  <= '0;
    end else begin
      if (en_q) begin
        if (cnt_q == '0) begin
          // reload or stop at terminal count
          if (cont_q) begin
            cnt_q <= val_q;
          end else begin
            en_q <= 1'b0;
          end
        end else begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
      // bus writes win over the count update
      if (wr_stb_i) begin
        case (sel_i)
          REG_TIM_CFG: begin
            if (wstrb_i[0]) begin
              en_q   <= wdata_i[0];
              cont_q <= wdata_i[1];
            end
          end
          REG_TIM_VAL: val_q <= merge_word(val_q, wdata_i, wstrb_i);
          REG_TIM_DAT: cnt_q <= merge_word(cnt_q, wdata_i, wstrb_i);
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (sel_i)
      REG_TIM_CFG: rdata_o = {30'd0, cont_q, en_q};
      REG_TIM_VAL: rdata_o = val_q;
      REG_TIM_DAT: rdata_o = cnt_q;
      default:     rdata_o = '0;
    endcase
  end

endmodule

/* mmio_sysinfo.sv */
//************************************************
// strap and ID read window
// packs static inputs into read words
//************************************************
`timescale 1ns/1ns
`include "mmio_consts.svh"

module mmio_sysinfo import mmio_pkg::*; (
  input  mmio_reg_e               sel_i,
  input  logic [7:0]              strap_cfg_i,
  input  logic                    xtal_ena_i,
  input  logic                    reg_ena_i,
  input  logic                    pll_cp_ena_i,
  input  logic                    pll_vco_ena_i,
  input  logic                    pll_bias_ena_i,
  input  logic [3:0]              pll_trim_i,
  input  logic [11:0]             mfgr_id_i,
  input  logic [7:0]              prod_id_i,
  input  logic [3:0]              mask_rev_i,
  input  logic                    clk_ext_sel_i,
  output logic [`MMIO_DATA_W-1:0] rdata_o
);

  always_comb begin
    case (sel_i)
      REG_STRAP_CFG:  rdata_o = {24'd0, strap_cfg_i};
      REG_STRAP_XTAL: rdata_o = {30'd0, xtal_ena_i, reg_ena_i};
      // trim in the upper bits, then cp, vco, bias
      REG_STRAP_PLL: begin
        rdata_o = {25'd0, pll_trim_i, pll_cp_ena_i, pll_vco_ena_i, pll_bias_ena_i};
      end
      REG_MFGR_ID:    rdata_o = {20'd0, mfgr_id_i};
      REG_PROD_ID:    rdata_o = {24'd0, prod_id_i};
      REG_MASK_REV:   rdata_o = {28'd0, mask_rev_i};
      REG_CLK_SEL:    rdata_o = {31'd0, clk_ext_sel_i};
      default:        rdata_o = '0;
    endcase
  end

endmodule

/* mmio_periph_top.sv */
//************************************************
// MMIO system peripheral block
// bus controller with gpio, timer and sysinfo
//************************************************
`timescale 1ns/1ns
`include "mmio_consts.svh"

module mmio_periph_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    mem_valid_i,
  input  logic [`MMIO_DATA_W-1:0] mem_addr_i,
  input  logic [`MMIO_DATA_W-1:0] mem_wdata_i,
  input  logic [3:0]              mem_wstrb_i,
  output logic                    mem_ready_o,
  output logic [`MMIO_DATA_W-1:0] mem_rdata_o,
  input  logic [`MMIO_GPIO_W-1:0] gpio_in_i,
  output logic [`MMIO_GPIO_W-1:0] gpio_out_o,
  output logic [`MMIO_GPIO_W-1:0] gpio_outenb_o,
  output logic [`MMIO_GPIO_W-1:0] gpio_pullupb_o,
  output logic [`MMIO_GPIO_W-1:0] gpio_pulldownb_o,
  input  logic [7:0]              strap_cfg_i,
  input  logic                    xtal_ena_i,
  input  logic                    reg_ena_i,
  input  logic                    pll_cp_ena_i,
  input  logic                    pll_vco_ena_i,
  input  logic                    pll_bias_ena_i,
  input  logic [3:0]              pll_trim_i,
  input  logic [11:0]             mfgr_id_i,
  input  logic [7:0]              prod_id_i,
  input  logic [3:0]              mask_rev_i,
  input  logic                    clk_ext_sel_i
);

  mmio_pkg::mmio_reg_e     sel;
  logic                    wr_stb;
  logic [`MMIO_DATA_W-1:0] gpio_rdata;
  logic [`MMIO_DATA_W-1:0] tim_rdata;
  logic [`MMIO_DATA_W-1:0] info_rdata;

  mmio_bus_ctrl u_bus_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .mem_valid_i  (mem_valid_i),
    .mem_addr_i   (mem_addr_i),
    .mem_wstrb_i  (mem_wstrb_i),
    .gpio_rdata_i (gpio_rdata),
    .tim_rdata_i  (tim_rdata),
    .info_rdata_i (info_rdata),
    .sel_o        (sel),
    .wr_stb_o     (wr_stb),
    .mem_ready_o  (mem_ready_o),
    .mem_rdata_o  (mem_rdata_o)
  );

  mmio_gpio_regs u_gpio_regs (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .sel_i            (sel),
    .wr_stb_i         (wr_stb),
    .wdata_i          (mem_wdata_i),
    .wstrb_i          (mem_wstrb_i),
    .gpio_in_i        (gpio_in_i),
    .rdata_o          (gpio_rdata),
    .gpio_out_o       (gpio_out_o),
    .gpio_outenb_o    (gpio_outenb_o),
    .gpio_pullupb_o   (gpio_pullupb_o),
    .gpio_pulldownb_o (gpio_pulldownb_o)
  );

  mmio_timer u_timer (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .sel_i    (sel),
    .wr_stb_i (wr_stb),
    .wdata_i  (mem_wdata_i),
    .wstrb_i  (mem_wstrb_i),
    .rdata_o  (tim_rdata)
  );

  mmio_sysinfo u_sysinfo (
    .sel_i          (sel),
    .strap_cfg_i    (strap_cfg_i),
    .xtal_ena_i     (xtal_ena_i),
    .reg_ena_i      (reg_ena_i),
    .pll_cp_ena_i   (pll_cp_ena_i),
    .pll_vco_ena_i  (pll_vco_ena_i),
    .pll_bias_ena_i (pll_bias_ena_i),
    .pll_trim_i     (pll_trim_i),
    .mfgr_id_i      (mfgr_id_i),
    .prod_id_i      (prod_id_i),
    .mask_rev_i     (mask_rev_i),
    .clk_ext_sel_i  (clk_ext_sel_i),
    .rdata_o        (info_rdata)
  );

endmodule

/* tb_mmio_periph.sv */
//************************************************
// MMIO peripheral testbench
// table-driven bus accesses with checks on read
// data and GPIO pins
//************************************************
`timescale 1ns/1ns
`include "mmio_consts.svh"

module tb_mmio_periph;

  localparam int CLK_HALF   = 10;
  localparam int READY_WAIT = 16;

  // row operations
  localparam int OP_WRITE = 0;
  localparam int OP_READ  = 1;
  localparam int OP_BELOW = 2;
  localparam int OP_STRAY = 3;
  localparam int OP_PINS  = 4;
  localparam int OP_IDLE  = 5;

  logic                    clk_i;
  logic                    rst_n_i;
  logic                    mem_valid_i;
  logic [`MMIO_DATA_W-1:0] mem_addr_i;
  logic [`MMIO_DATA_W-1:0] mem_wdata_i;
  logic [3:0]              mem_wstrb_i;
  logic                    mem_ready_o;
  logic [`MMIO_DATA_W-1:0] mem_rdata_o;
  logic [`MMIO_GPIO_W-1:0] gpio_in_i;
  logic [`MMIO_GPIO_W-1:0] gpio_out_o;
  logic [`MMIO_GPIO_W-1:0] gpio_outenb_o;
  logic [`MMIO_GPIO_W-1:0] gpio_pullupb_o;
  logic [`MMIO_GPIO_W-1:0] gpio_pulldownb_o;
  logic [7:0]              strap_cfg_i;
  logic                    xtal_ena_i;
  logic                    reg_ena_i;
  logic                    pll_cp_ena_i;
  logic                    pll_vco_ena_i;
  logic                    pll_bias_ena_i;
  logic [3:0]              pll_trim_i;
  logic [11:0]             mfgr_id_i;
  logic [7:0]              prod_id_i;
  logic [3:0]              mask_rev_i;
  logic                    clk_ext_sel_i;

  int errors;
  int checks;

  // stimulus table with one entry per row in each queue
  int          op_q[$];
  logic [7:0]  off_q[$];
  logic [3:0]  strb_q[$];
  logic [31:0] wd_q[$];
  logic [31:0] exp_q[$];

  mmio_periph_top i_mmio_periph_top (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .mem_valid_i      (mem_valid_i),
    .mem_addr_i       (mem_addr_i),
    .mem_wdata_i      (mem_wdata_i),
    .mem_wstrb_i      (mem_wstrb_i),
    .mem_ready_o      (mem_ready_o),
    .mem_rdata_o      (mem_rdata_o),
    .gpio_in_i        (gpio_in_i),
    .gpio_out_o       (gpio_out_o),
    .gpio_outenb_o    (gpio_outenb_o),
    .gpio_pullupb_o   (gpio_pullupb_o),
    .gpio_pulldownb_o (gpio_pulldownb_o),
    .strap_cfg_i      (strap_cfg_i),
    .xtal_ena_i       (xtal_ena_i),
    .reg_ena_i        (reg_ena_i),
    .pll_cp_ena_i     (pll_cp_ena_i),
    .pll_vco_ena_i    (pll_vco_ena_i),
    .pll_bias_ena_i   (pll_bias_ena_i),
    .pll_trim_i       (pll_trim_i),
    .mfgr_id_i        (mfgr_id_i),
    .prod_id_i        (prod_id_i),
    .mask_rev_i       (mask_rev_i),
    .clk_ext_sel_i    (clk_ext_sel_i)
  );

  always #CLK_HALF clk_i = ~clk_i;

  task automatic add_row(input int op, input logic [7:0] off, input logic [3:0] strb,
                         input logic [31:0] wd, input logic [31:0] exp);
    op_q.push_back(op);
    off_q.push_back(off);
    strb_q.push_back(strb);
    wd_q.push_back(wd);
    exp_q.push_back(exp);
  endtask

  task automatic check_word(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_gpio(input string name, input logic [15:0] exp,
                            input logic [15:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // counter keeps running so only a range is known
  task automatic check_below(input string name, input logic [31:0] bound,
                             input logic [31:0] act);
    checks++;
    if ($isunknown(act) || act == '0 || act >= bound) begin
      errors++;
      $display("** Error at %0t ns: %s expected nonzero below %h, got %h",
               $time, name, bound, act);
    end
  endtask

  // called and returns on a falling edge
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, input bit may_stall,
                            output logic [31:0] rdata, output bit got);
    int waited;
    got         = 1'b0;
    waited      = 0;
    rdata       = '0;
    mem_valid_i = 1'b1;
    mem_addr_i  = addr;
    mem_wdata_i = wdata;
    mem_wstrb_i = wstrb;
    while (!got && waited < READY_WAIT) begin
      @(negedge clk_i);
      if (mem_ready_o) begin
        got   = 1'b1;
        rdata = mem_rdata_o;
      end else begin
        waited++;
      end
    end
    // let the completing rising edge pass
    if (got) @(negedge clk_i);
    mem_valid_i = 1'b0;
    mem_addr_i  = '0;
    mem_wdata_i = '0;
    mem_wstrb_i = '0;
    if (!got && !may_stall) begin
      errors++;
      $display("Timeout at %0t ns: ready never came for the access at %h", $time, addr);
    end
  endtask

  task automatic bus_write(input logic [7:0] off, input logic [31:0] wdata,
                           input logic [3:0] wstrb);
    logic [31:0] unused;
    bit          got;
    bus_access({`MMIO_BASE, off}, wdata, wstrb, 1'b0, unused, got);
  endtask

  task automatic bus_read(input logic [7:0] off, output logic [31:0] rdata);
    bit got;
    bus_access({`MMIO_BASE, off}, '0, 4'b0000, 1'b0, rdata, got);
  endtask

  initial begin
    logic [31:0] rd;
    bit          got;
    int          row;
    void'($urandom(32'h149ddd46));
    errors        = 0;
    checks        = 0;
    clk_i         = 1'b0;
    rst_n_i       = 1'b0;
    mem_valid_i   = 1'b0;
    mem_addr_i    = '0;
    mem_wdata_i   = '0;
    mem_wstrb_i   = '0;
    gpio_in_i     = $urandom;
    strap_cfg_i   = $urandom;
    xtal_ena_i    = $urandom;
    reg_ena_i     = $urandom;
    pll_cp_ena_i  = $urandom;
    pll_vco_ena_i = $urandom;
    pll_bias_ena_i = $urandom;
    pll_trim_i    = $urandom;
    mfgr_id_i     = $urandom;
    prod_id_i     = $urandom;
    mask_rev_i    = $urandom;
    clk_ext_sel_i = $urandom;

    // reset values and the forced oeb
    add_row(OP_PINS, 8'h00, 4'h0, {16'h0000, 16'hffff}, {16'h0000, 16'h0000});
    add_row(OP_READ, `MMIO_OFF_GPIO_OEB, 4'h0, '0, 32'h0000_ffff);
    add_row(OP_READ, `MMIO_OFF_GPIO_PU, 4'h0, '0, 32'h0);
    add_row(OP_READ, `MMIO_OFF_GPIO_PD, 4'h0, '0, 32'h0);
    add_row(OP_READ, `MMIO_OFF_GPIO_DAT, 4'h0, '0, {16'h0000, gpio_in_i});
    add_row(OP_READ, `MMIO_OFF_TIM_CFG, 4'h0, '0, 32'h0);
    add_row(OP_READ, `MMIO_OFF_TIM_VAL, 4'h0, '0, 32'h0);
    add_row(OP_READ, `MMIO_OFF_TIM_DAT, 4'h0, '0, 32'h0);
    // low byte writes leave the high byte alone
    add_row(OP_WRITE, `MMIO_OFF_GPIO_DAT, 4'b0001, 32'h0000_c33c, '0);
    add_row(OP_WRITE, `MMIO_OFF_GPIO_OEB, 4'b0001, 32'h0000_a55a, '0);
    add_row(OP_WRITE, `MMIO_OFF_GPIO_PU, 4'b0001, 32'h0000_9966, '0);
    add_row(OP_WRITE, `MMIO_OFF_GPIO_PD, 4'b0001, 32'h0000_7788, '0);
    add_row(OP_PINS, 8'h00, 4'h0, {16'h003c, 16'hff5a}, {16'h0066, 16'h0088});
    add_row(OP_READ, `MMIO_OFF_GPIO_DAT, 4'h0, '0, {16'h003c, gpio_in_i});
    add_row(OP_READ, `MMIO_OFF_GPIO_OEB, 4'h0, '0, 32'h0000_ff5a);
    add_row(OP_READ, `MMIO_OFF_GPIO_PU, 4'h0, '0, 32'h0000_0066);
    add_row(OP_READ, `MMIO_OFF_GPIO_PD, 4'h0, '0, 32'h0000_0088);
    add_row(OP_WRITE, `MMIO_OFF_GPIO_DAT, 4'b0010, 32'h0000_a5ff, '0);
    add_row(OP_WRITE, `MMIO_OFF_GPIO_PD, 4'b0011, 32'h0000_1188, '0);
    add_row(OP_PINS, 8'h00, 4'h0, {16'ha53c, 16'hff5a}, {16'h0066, 16'h1188});
    add_row(OP_READ, `MMIO_OFF_GPIO_DAT, 4'h0, '0, {16'ha53c, gpio_in_i});
    add_row(OP_READ, `MMIO_OFF_GPIO_PD, 4'h0, '0, 32'h0000_1188);
    // strap and id packing
    add_row(OP_READ, `MMIO_OFF_STRAP_CFG, 4'h0, '0, {24'd0, strap_cfg_i});
    add_row(OP_READ, `MMIO_OFF_STRAP_XTAL, 4'h0, '0, {30'd0, xtal_ena_i, reg_ena_i});
    add_row(OP_READ, `MMIO_OFF_STRAP_PLL, 4'h0, '0,
            {25'd0, pll_trim_i, pll_cp_ena_i, pll_vco_ena_i, pll_bias_ena_i});
    add_row(OP_READ, `MMIO_OFF_MFGR_ID, 4'h0, '0, {20'd0, mfgr_id_i});
    add_row(OP_READ, `MMIO_OFF_PROD_ID, 4'h0, '0, {24'd0, prod_id_i});
    add_row(OP_READ, `MMIO_OFF_MASK_REV, 4'h0, '0, {28'd0, mask_rev_i});
    add_row(OP_READ, `MMIO_OFF_CLK_SEL, 4'h0, '0, {31'd0, clk_ext_sel_i});
    // a write outside the window must not land
    add_row(OP_STRAY, `MMIO_OFF_GPIO_OEB, 4'b0011, 32'h0000_0000, '0);
    add_row(OP_READ, `MMIO_OFF_GPIO_OEB, 4'h0, '0, 32'h0000_ff5a);
    // holes in the window read zero
    add_row(OP_READ, 8'h10, 4'h0, '0, 32'h0);
    add_row(OP_READ, 8'h40, 4'h0, '0, 32'h0);
    // one-shot from 5, then stopped
    add_row(OP_WRITE, `MMIO_OFF_TIM_DAT, 4'b1111, 32'd5, '0);
    add_row(OP_WRITE, `MMIO_OFF_TIM_CFG, 4'b0001, 32'd1, '0);
    add_row(OP_IDLE, 8'h00, 4'h0, 32'd20, '0);
    add_row(OP_READ, `MMIO_OFF_TIM_DAT, 4'h0, '0, 32'h0);
    add_row(OP_READ, `MMIO_OFF_TIM_CFG, 4'h0, '0, 32'h0);
    // continuous with a large reload
    add_row(OP_WRITE, `MMIO_OFF_TIM_VAL, 4'b1111, 32'h0000_1000, '0);
    add_row(OP_WRITE, `MMIO_OFF_TIM_DAT, 4'b1111, 32'h0000_1000, '0);
    add_row(OP_WRITE, `MMIO_OFF_TIM_CFG, 4'b0001, 32'd3, '0);
    add_row(OP_IDLE, 8'h00, 4'h0, 32'd10, '0);
    add_row(OP_BELOW, `MMIO_OFF_TIM_DAT, 4'h0, '0, 32'h0000_1000);
    add_row(OP_READ, `MMIO_OFF_TIM_CFG, 4'h0, '0, 32'd3);
    add_row(OP_READ, `MMIO_OFF_TIM_VAL, 4'h0, '0, 32'h0000_1000);

    repeat (2) @(negedge clk_i);
    check_gpio("gpio_outenb_o", 16'hffff, gpio_outenb_o);
    repeat (2) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);

    for (row = 0; row < op_q.size(); row++) begin
      case (op_q[row])
        OP_WRITE: bus_write(off_q[row], wd_q[row], strb_q[row]);
        OP_READ: begin
          bus_read(off_q[row], rd);
          check_word($sformatf("mem_rdata_o[%h]", off_q[row]), exp_q[row], rd);
        end
        OP_BELOW: begin
          bus_read(off_q[row], rd);
          check_below($sformatf("mem_rdata_o[%h]", off_q[row]), exp_q[row], rd);
        end
        OP_STRAY: begin
          bus_access({`MMIO_BASE + 24'h1, off_q[row]}, wd_q[row], strb_q[row], 1'b1,
                     rd, got);
          checks++;
          if (got) begin
            errors++;
            $display("Access outside the window at %0t ns was answered with ready", $time);
          end
        end
        OP_PINS: begin
          check_gpio("gpio_out_o", wd_q[row][31:16], gpio_out_o);
          check_gpio("gpio_outenb_o", wd_q[row][15:0], gpio_outenb_o);
          check_gpio("gpio_pullupb_o", exp_q[row][31:16], gpio_pullupb_o);
          check_gpio("gpio_pulldownb_o", exp_q[row][15:0], gpio_pulldownb_o);
        end
        default: repeat (wd_q[row]) @(negedge clk_i);
      endcase
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+.
mmio_pkg.sv
mmio_bus_ctrl.sv
mmio_gpio_regs.sv
mmio_timer.sv
mmio_sysinfo.sv
mmio_periph_top.sv
tb_mmio_periph.sv

/* Bender.yml */
package:
  name: mmio_periph

# mmio_consts.svh is picked up through the include directory
export_include_dirs:
  - .

sources:
  - files:
      - mmio_pkg.sv
      - mmio_bus_ctrl.sv
      - mmio_gpio_regs.sv
      - mmio_timer.sv
      - mmio_sysinfo.sv
      - mmio_periph_top.sv
  - target: test
    files:
      - tb_mmio_periph.sv
